//--- files.f
hdl/mcoi_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/frame_ctrl.sv
hdl/stepper_gen.sv
hdl/mcoi_xu5_design_complete.sv
verif/tb_clk.sv
verif/mcoi_monitor.sv
verif/mcoi_chk.sv
verif/mcoi_tb.sv

//--- hdl/frame_ctrl.sv
//------------------------------------------------
// command frame decoder and status reply sequencer
// three received bytes form a frame, header first
// moves and period loads go out as one-hot pulses
// status replies are queued one deep for the uart
//------------------------------------------------

`timescale 1ns/1ns

module frame_ctrl import mcoi_pkg::*; #(
   parameter int NMOTORS = 16
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [7:0]                    rx_data,
   input  logic                          rx_strobe,
   output logic [7:0]                    tx_data,
   output logic                          tx_load,
   input  logic                          tx_busy,
   output logic [NMOTORS-1:0]            cmd_move,
   output logic [NMOTORS-1:0]            cmd_period,
   output logic                          cmd_dir,
   output logic [POS_W-1:0]              cmd_arg,
   input  logic [NMOTORS-1:0][POS_W-1:0] position
);

   localparam int REPLY_W = 8 * FRAME_BYTES;
   localparam logic [1:0] LAST_BYTE = 2'(FRAME_BYTES - 1);

   //------------------------------------------------
   // frame assembly
   //------------------------------------------------
   logic [1:0]             byte_cnt;
   logic [7:0]             hdr;
   logic [7:0]             arg_hi;
   logic                   frame_done;
   logic [1:0]             op;
   logic [MOTOR_IDX_W-1:0] idx;
   logic                   in_range;
   logic                   status_done;
   logic [POS_W-1:0]       pos_sel;

   // reply path
   logic [REPLY_W-1:0]     new_rep;
   logic [REPLY_W-1:0]     rep_src;
   logic [REPLY_W-1:0]     pend_q;
   logic                   pend_vld;
   logic [REPLY_W-9:0]     rep_q;
   logic [1:0]             rep_cnt;
   logic                   tx_free;
   logic                   next_byte;
   logic                   start;

   // third byte of a frame arriving
   assign frame_done  = rx_strobe && byte_cnt == LAST_BYTE;
   assign op          = hdr[7:6];
   assign idx         = hdr[MOTOR_IDX_W-1:0];
   assign in_range    = int'(idx) < NMOTORS;
   assign status_done = frame_done && in_range && op == OP_STATUS;

   // position of the addressed motor, zero when out of range
   always_comb begin
      pos_sel = '0;
      for (int i = 0; i < NMOTORS; i++) begin
         if (idx == MOTOR_IDX_W'(i)) begin
            pos_sel = position[i];
         end
      end
   end

   //------------------------------------------------
   // reply sequencing
   //------------------------------------------------
   // header echo, then position high and low
   assign new_rep = {hdr, pos_sel};
   // a waiting reply goes before a new one
   assign rep_src = pend_vld ? pend_q : new_rep;

   // uart idle and no load in flight
   assign tx_free   = !tx_busy && !tx_load;
   assign next_byte = tx_free && rep_cnt != 2'd0;
   assign start     = tx_free && rep_cnt == 2'd0 && (pend_vld || status_done);

   always_ff @(posedge clk) begin
      if (rst) begin
         byte_cnt   <= '0;
         cmd_move   <= '0;
         cmd_period <= '0;
         tx_load    <= 1'b0;
         rep_cnt    <= '0;
         pend_vld   <= 1'b0;
      end else begin
         if (rx_strobe) begin
            byte_cnt <= frame_done ? 2'd0 : byte_cnt + 1'b1;
         end
         // one-hot pulses, indexes past NMOTORS match nothing
         for (int i = 0; i < NMOTORS; i++) begin
            cmd_move[i]   <= frame_done && idx == MOTOR_IDX_W'(i) &&
                             (op == OP_MOVE_FWD || op == OP_MOVE_REV);
            cmd_period[i] <= frame_done && idx == MOTOR_IDX_W'(i) &&
                             op == OP_SET_PERIOD;
         end
         tx_load <= next_byte || start;
         if (start) begin
            rep_cnt <= LAST_BYTE;
         end else if (next_byte) begin
            rep_cnt <= rep_cnt - 1'b1;
         end
         // park a new reply unless it went straight out
         if (status_done && !(start && !pend_vld)) begin
            pend_vld <= 1'b1;
         end else if (start) begin
            pend_vld <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_strobe && byte_cnt == 2'd0) begin
         hdr <= rx_data;
      end
      if (rx_strobe && byte_cnt == 2'd1) begin
         arg_hi <= rx_data;
      end
      if (frame_done) begin
         cmd_arg <= {arg_hi, rx_data};
         cmd_dir <= op == OP_MOVE_REV;
      end
      if (start) begin
         tx_data <= rep_src[REPLY_W-1 -: 8];
         rep_q   <= rep_src[REPLY_W-9:0];
      end else if (next_byte) begin
         tx_data <= rep_q[REPLY_W-9 -: 8];
         rep_q   <= rep_q << 8;
      end
      if (status_done) begin
         pend_q <= new_rep;
      end
   end

endmodule : frame_ctrl

//--- hdl/mcoi_pkg.sv
//------------------------------------------------
// shared constants for the motor control design
// frame opcodes, field widths and reset defaults
// imported by the RTL and the testbench
//------------------------------------------------

package mcoi_pkg;

   //------------------------------------------------
   // frame header opcodes, top two bits of byte 0
   //------------------------------------------------
   localparam logic [1:0] OP_MOVE_FWD   = 2'b00;
   localparam logic [1:0] OP_MOVE_REV   = 2'b01;
   localparam logic [1:0] OP_SET_PERIOD = 2'b10;
   localparam logic [1:0] OP_STATUS     = 2'b11;

   //------------------------------------------------
   // field widths
   //------------------------------------------------
   // motor index in the low header bits
   localparam int MOTOR_IDX_W = 6;

   // position, step count and period argument
   localparam int POS_W = 16;

   // header plus two argument bytes, same for replies
   localparam int FRAME_BYTES = 3;

   //------------------------------------------------
   // defaults
   //------------------------------------------------
   // step half period in clocks after reset
   localparam logic [15:0] DEFAULT_HALF_PERIOD = 16'd100;

endpackage : mcoi_pkg

//--- hdl/mcoi_xu5_design_complete.sv
//------------------------------------------------
// motor controller top level
// RS485 commands in, replies out, one stepper per motor
// busy levels form the diagnostics outputs
//------------------------------------------------

`timescale 1ns/1ns

module mcoi_xu5_design_complete import mcoi_pkg::*; #(
   parameter int CLKS_PER_BIT = 868,
   parameter int NMOTORS      = 16
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               rs485_pl_di,
   output logic               rs485_pl_ro,
   output logic [NMOTORS-1:0] step,
   output logic [NMOTORS-1:0] dir,
   output logic [NMOTORS-1:0] busy
);

   // serial side
   logic [7:0]                   rx_data;
   logic                         rx_strobe;
   logic [7:0]                   tx_data;
   logic                         tx_load;
   logic                         tx_busy;

   // motor side
   logic [NMOTORS-1:0]           cmd_move;
   logic [NMOTORS-1:0]           cmd_period;
   logic                         cmd_dir;
   logic [POS_W-1:0]             cmd_arg;
   logic [NMOTORS-1:0][POS_W-1:0] position;

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) i_uart_rx (
      .clk         (clk),
      .rst         (rst),
      .rs485_pl_di (rs485_pl_di),
      .rx_data     (rx_data),
      .rx_strobe   (rx_strobe)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) i_uart_tx (
      .clk         (clk),
      .rst         (rst),
      .tx_data     (tx_data),
      .tx_load     (tx_load),
      .rs485_pl_ro (rs485_pl_ro),
      .tx_busy     (tx_busy)
   );

   frame_ctrl #(
      .NMOTORS (NMOTORS)
   ) i_frame_ctrl (
      .clk        (clk),
      .rst        (rst),
      .rx_data    (rx_data),
      .rx_strobe  (rx_strobe),
      .tx_data    (tx_data),
      .tx_load    (tx_load),
      .tx_busy    (tx_busy),
      .cmd_move   (cmd_move),
      .cmd_period (cmd_period),
      .cmd_dir    (cmd_dir),
      .cmd_arg    (cmd_arg),
      .position   (position)
   );

   //------------------------------------------------
   // one generator per motor, shared dir and argument
   //------------------------------------------------
   for (genvar m = 0; m < NMOTORS; m++) begin : g_motor
      stepper_gen i_stepper_gen (
         .clk        (clk),
         .rst        (rst),
         .cmd_move   (cmd_move[m]),
         .cmd_period (cmd_period[m]),
         .cmd_dir    (cmd_dir),
         .cmd_arg    (cmd_arg),
         .step       (step[m]),
         .dir        (dir[m]),
         .busy       (busy[m]),
         .position   (position[m])
      );
   end

endmodule : mcoi_xu5_design_complete

//--- hdl/stepper_gen.sv
//------------------------------------------------
// step and direction generator for one motor
// cmd_move starts a run of cmd_arg steps
// cmd_period sets the half period for later phases
//------------------------------------------------

`timescale 1ns/1ns

module stepper_gen import mcoi_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cmd_move,
   input  logic                    cmd_period,
   input  logic                    cmd_dir,
   input  logic [POS_W-1:0]        cmd_arg,
   output logic                    step,
   output logic                    dir,
   output logic                    busy,
   output logic signed [POS_W-1:0] position
);

   logic [POS_W-1:0] half_period;
   // length of the running phase
   logic [POS_W-1:0] phase_len;
   logic [POS_W-1:0] phase_cnt;
   // pulses still to come after the current one
   logic [POS_W-1:0] steps_left;
   logic             phase_end;
   logic             start;

   // one extra bit so a zero period gives one clock phases
   assign phase_end = {1'b0, phase_cnt} + 1'b1 >= {1'b0, phase_len};
   // moves while busy and empty moves are dropped
   assign start     = cmd_move && !busy && cmd_arg != '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         half_period <= DEFAULT_HALF_PERIOD;
         phase_len   <= DEFAULT_HALF_PERIOD;
         phase_cnt   <= '0;
         steps_left  <= '0;
         step        <= 1'b0;
         dir         <= 1'b0;
         busy        <= 1'b0;
         position    <= '0;
      end else begin
         if (cmd_period) begin
            half_period <= cmd_arg;
         end
         if (start) begin
            // first rising edge right away
            busy       <= 1'b1;
            step       <= 1'b1;
            dir        <= cmd_dir;
            steps_left <= cmd_arg - 1'b1;
            phase_cnt  <= '0;
            phase_len  <= half_period;
            // dir high counts down
            position   <= cmd_dir ? position - 1'b1 : position + 1'b1;
         end else if (busy) begin
            if (phase_end) begin
               phase_cnt <= '0;
               phase_len <= half_period;
               if (step) begin
                  step <= 1'b0;
               end else if (steps_left != '0) begin
                  step       <= 1'b1;
                  steps_left <= steps_left - 1'b1;
                  position   <= dir ? position - 1'b1 : position + 1'b1;
               end else begin
                  // last low phase done
                  busy <= 1'b0;
               end
            end else begin
               phase_cnt <= phase_cnt + 1'b1;
            end
         end
      end
   end

endmodule : stepper_gen

//--- hdl/uart_rx.sv
//------------------------------------------------
// 8N1 serial receiver for the RS485 input pin
// strobes rx_data for one cycle per good byte
// bytes with a low stop bit are dropped
//------------------------------------------------

`timescale 1ns/1ns

module uart_rx #(
   parameter int CLKS_PER_BIT = 868
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       rs485_pl_di,
   output logic [7:0] rx_data,
   output logic       rx_strobe
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   // last clock of a full bit
   localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);
   // middle of the start bit
   localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

   typedef enum logic [1:0] {
      S_IDLE,
      S_START,
      S_DATA,
      S_STOP
   } state_t;

   state_t           state;
   logic [1:0]       sync;
   logic             line;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;

   // two flop synchronizer, idle level is high
   always_ff @(posedge clk) begin
      if (rst) begin
         sync <= 2'b11;
      end else begin
         sync <= {sync[0], rs485_pl_di};
      end
   end

   assign line = sync[1];

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= S_IDLE;
         cnt       <= '0;
         bit_idx   <= '0;
         rx_strobe <= 1'b0;
      end else begin
         rx_strobe <= 1'b0;
         case (state)
            S_IDLE: begin
               cnt <= '0;
               // falling edge of the start bit
               if (!line) begin
                  state <= S_START;
               end
            end
            S_START: begin
               if (cnt == HALF_END) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  // glitch shorter than half a bit goes back to idle
                  state   <= line ? S_IDLE : S_DATA;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            S_DATA: begin
               if (cnt == BIT_END) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= S_STOP;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: begin
               // stop bit middle, strobe only on a high stop bit
               if (cnt == BIT_END) begin
                  cnt       <= '0;
                  rx_strobe <= line;
                  state     <= S_IDLE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // lsb first, sampled at each data bit middle
   always_ff @(posedge clk) begin
      if (state == S_DATA && cnt == BIT_END) begin
         rx_data <= {line, rx_data[7:1]};
      end
   end

endmodule : uart_rx

//--- hdl/uart_tx.sv
//------------------------------------------------
// 8N1 serial transmitter for the RS485 output pin
// load a byte while tx_busy is low
// tx_busy stays high until the stop bit is out
//------------------------------------------------

`timescale 1ns/1ns

module uart_tx #(
   parameter int CLKS_PER_BIT = 868
) (
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] tx_data,
   input  logic       tx_load,
   output logic       rs485_pl_ro,
   output logic       tx_busy
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

   // stop, data, start from msb down to lsb
   logic [9:0]       shreg;
   logic [CNT_W-1:0] cnt;
   logic [3:0]       bit_cnt;

   // line idles high between bytes
   assign rs485_pl_ro = tx_busy ? shreg[0] : 1'b1;

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_busy <= 1'b0;
         cnt     <= '0;
         bit_cnt <= '0;
      end else if (!tx_busy) begin
         cnt     <= '0;
         bit_cnt <= '0;
         if (tx_load) begin
            tx_busy <= 1'b1;
         end
      end else if (cnt == BIT_END) begin
         cnt <= '0;
         // ten bits sent, stop bit complete
         if (bit_cnt == 4'd9) begin
            tx_busy <= 1'b0;
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!tx_busy && tx_load) begin
         shreg <= {1'b1, tx_data, 1'b0};
      end else if (tx_busy && cnt == BIT_END) begin
         shreg <= {1'b1, shreg[9:1]};
      end
   end

endmodule : uart_tx

//--- run.sh
#!/usr/bin/env bash
# build and run the motor controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module mcoi_tb -f files.f -o mcoi_sim

# keep running past assertion errors so the testbench reports them
status=0
out=$(./obj_dir/mcoi_sim +verilator+error+limit+1000 2>&1) || status=$?
echo "$out"

if grep -qx "Regression passed" <<< "$out"; then
   exit 0
fi
echo "simulation exit status ${status}"
exit 1

//--- verif/mcoi_chk.sv
//------------------------------------------------
// concurrent checks on the top level ports
// bound into the motor controller top level
//------------------------------------------------

`timescale 1ns/1ns

module mcoi_chk #(
   parameter int NMOTORS = 4
) (
   input logic               clk,
   input logic               rst,
   input logic               rs485_pl_ro,
   input logic [NMOTORS-1:0] step,
   input logic [NMOTORS-1:0] dir,
   input logic [NMOTORS-1:0] busy
);

   // failures seen, read back by the testbench top
   int fail_cnt = 0;

   // dir frozen while a pulse is high, all motors at once
   dir_stable_a: assert property (@(posedge clk) disable iff (rst)
      (step & $past(step) & (dir ^ $past(dir))) == '0)
      else begin
         fail_cnt++;
         $error("dir changed during a step pulse");
      end

   // a pulse only inside a run
   step_busy_a: assert property (@(posedge clk) disable iff (rst)
      (step & ~busy) == '0)
      else begin
         fail_cnt++;
         $error("step high on a motor that is not busy");
      end

   // transmit line idles high through reset
   tx_idle_a: assert property (@(posedge clk) rst && $past(rst) |-> rs485_pl_ro)
      else begin
         fail_cnt++;
         $error("RS485 output low during reset");
      end

endmodule : mcoi_chk

bind mcoi_xu5_design_complete mcoi_chk #(
   .NMOTORS (NMOTORS)
) chk_inst (
   .clk         (clk),
   .rst         (rst),
   .rs485_pl_ro (rs485_pl_ro),
   .step        (step),
   .dir         (dir),
   .busy        (busy)
);

//--- verif/mcoi_monitor.sv
//------------------------------------------------
// checker for the motor controller testbench
// counts step pulses, times the high phase, checks dir
// decodes reply bytes from the RS485 output pin
// expected values are pushed in by the testbench top
//------------------------------------------------

`timescale 1ns/1ns

module mcoi_monitor import mcoi_pkg::*; #(
   parameter int NMOTORS      = 4,
   parameter int CLKS_PER_BIT = 8
) (
   input logic               clk,
   input logic               rst,
   input logic               rs485_pl_ro,
   input logic [NMOTORS-1:0] step,
   input logic [NMOTORS-1:0] dir,
   input logic [NMOTORS-1:0] busy
);

   int         value_errs;
   int         timeout_errs;
   string      test_name;

   // per motor counters and expectations
   int         step_cnt [NMOTORS];
   int         exp_cnt [NMOTORS];
   logic       exp_dir [NMOTORS];
   int         exp_half [NMOTORS];
   int         hi_cnt [NMOTORS];
   logic [NMOTORS-1:0] step_q;
   logic [NMOTORS-1:0] busy_q;

   // reply bytes in the order they should leave the pin
   logic [7:0] exp_bytes [$];

   initial begin
      value_errs   = 0;
      timeout_errs = 0;
      test_name    = "init";
      for (int m = 0; m < NMOTORS; m++) begin
         step_cnt[m] = 0;
         exp_cnt[m]  = 0;
         exp_dir[m]  = 1'b0;
         exp_half[m] = int'(DEFAULT_HALF_PERIOD);
         hi_cnt[m]   = 0;
      end
   end

   //------------------------------------------------
   // hooks for the testbench top
   //------------------------------------------------
   task automatic compare(input string what, input int expected, input int actual);
      if (expected != actual) begin
         value_errs++;
         $display("Fail %s: %s expected 0x%0h actual 0x%0h",
                  test_name, what, expected, actual);
      end
   endtask

   task automatic set_test(input string name);
      test_name = name;
   endtask

   // steps add up over the whole run
   task automatic expect_move(input int m, input int n, input logic d);
      exp_cnt[m] += n;
      exp_dir[m]  = d;
   endtask

   task automatic expect_half(input int m, input int h);
      exp_half[m] = h;
   endtask

   task automatic expect_byte(input logic [7:0] b);
      exp_bytes.push_back(b);
   endtask

   function automatic int pending_bytes();
      return exp_bytes.size();
   endfunction

   task automatic note_timeout();
      timeout_errs++;
   endtask

   // all motors at rest
   task automatic check_idle();
      @(negedge clk);
      compare("step after reset", 0, int'(step));
      compare("busy after reset", 0, int'(busy));
   endtask

   task automatic final_check();
      for (int m = 0; m < NMOTORS; m++) begin
         compare($sformatf("motor %0d total steps", m), exp_cnt[m], step_cnt[m]);
      end
      if (exp_bytes.size() != 0) begin
         value_errs++;
         $display("%0d reply bytes never arrived", exp_bytes.size());
      end
   endtask

   task automatic report(input int assert_errs);
      $display("errors: %0d value, %0d timeout, %0d assertion",
               value_errs, timeout_errs, assert_errs);
   endtask

   //------------------------------------------------
   // step watch, sampled away from the rising edge
   //------------------------------------------------
   always @(negedge clk) begin
      if (rst) begin
         step_q = '0;
         busy_q = '0;
      end else begin
         for (int m = 0; m < NMOTORS; m++) begin
            if (step[m] && !step_q[m]) begin
               step_cnt[m]++;
               hi_cnt[m] = 1;
               compare($sformatf("motor %0d dir", m), int'(exp_dir[m]), int'(dir[m]));
            end else if (step[m]) begin
               hi_cnt[m]++;
            end
            // high phase just ended
            if (!step[m] && step_q[m]) begin
               compare($sformatf("motor %0d step high time", m), exp_half[m], hi_cnt[m]);
            end
            // run finished, count must match
            if (!busy[m] && busy_q[m]) begin
               compare($sformatf("motor %0d step count", m), exp_cnt[m], step_cnt[m]);
            end
         end
         step_q = step;
         busy_q = busy;
      end
   end

   //------------------------------------------------
   // reply decoder, samples at bit middles
   //------------------------------------------------
   always begin : decode
      logic [7:0] got;
      logic [7:0] want;
      @(negedge clk);
      if (!rst && !rs485_pl_ro) begin
         // half a bit in, roughly mid start bit
         repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
         if (!rs485_pl_ro) begin
            for (int i = 0; i < 8; i++) begin
               repeat (CLKS_PER_BIT) @(negedge clk);
               got[i] = rs485_pl_ro;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (!rs485_pl_ro) begin
               value_errs++;
               $display("reply byte 0x%0h in %s has a low stop bit", got, test_name);
            end
            if (exp_bytes.size() == 0) begin
               value_errs++;
               $display("unexpected reply byte 0x%0h in %s", got, test_name);
            end else begin
               want = exp_bytes.pop_front();
               compare("reply byte", int'(want), int'(got));
            end
         end
      end
   end

endmodule : mcoi_monitor

//--- verif/mcoi_tb.sv
//------------------------------------------------
// testbench top for the motor controller
// sends serial command frames, keeps a motor model
// expected steps and reply bytes go to the monitor
//------------------------------------------------

`timescale 1ns/1ns

module mcoi_tb import mcoi_pkg::*; ();

   localparam int CLKS_PER_BIT = 8;
   localparam int NMOTORS      = 4;
   localparam int WAIT_LIMIT   = 5000;

   logic               clk;
   logic               rst;
   logic               rs485_pl_di;
   logic               rs485_pl_ro;
   logic [NMOTORS-1:0] step;
   logic [NMOTORS-1:0] dir;
   logic [NMOTORS-1:0] busy;

   // motor model
   logic signed [POS_W-1:0] model_pos [NMOTORS];
   logic [POS_W-1:0]        model_half [NMOTORS];
   logic                    model_dir [NMOTORS];

   tb_clk #(.RST_CYCLES (8)) clk_gen (.clk (clk), .rst (rst));

   mcoi_xu5_design_complete #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .NMOTORS      (NMOTORS)
   ) mcoi_xu5_design_complete_inst (
      .clk         (clk),
      .rst         (rst),
      .rs485_pl_di (rs485_pl_di),
      .rs485_pl_ro (rs485_pl_ro),
      .step        (step),
      .dir         (dir),
      .busy        (busy)
   );

   mcoi_monitor #(
      .NMOTORS      (NMOTORS),
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) mon (
      .clk         (clk),
      .rst         (rst),
      .rs485_pl_ro (rs485_pl_ro),
      .step        (step),
      .dir         (dir),
      .busy        (busy)
   );

   //------------------------------------------------
   // reference model of one frame
   //------------------------------------------------
   // steps and dir of a move, reply of a status request
   function automatic void ref_model(input logic [1:0] op, input int m,
                                     input logic [15:0] arg, input bit ignored,
                                     output int steps, output logic exp_dir,
                                     output logic [23:0] reply);
      steps   = 0;
      exp_dir = 1'b0;
      reply   = '0;
      // out of range index, frame dropped
      if (m < NMOTORS) begin
         case (op)
            OP_MOVE_FWD, OP_MOVE_REV: begin
               if (!ignored && arg != 16'd0) begin
                  steps        = int'(arg);
                  model_dir[m] = op == OP_MOVE_REV;
                  model_pos[m] = model_dir[m] ? model_pos[m] - arg : model_pos[m] + arg;
               end
            end
            OP_SET_PERIOD: model_half[m] = arg;
            default: reply = {OP_STATUS, MOTOR_IDX_W'(m), model_pos[m]};
         endcase
         exp_dir = model_dir[m];
      end
   endfunction

   //------------------------------------------------
   // serial stimulus
   //------------------------------------------------
   task automatic send_byte(input logic [7:0] b);
      logic [9:0] bits;
      bits = {1'b1, b, 1'b0};
      // lsb first, start bit leads
      for (int i = 0; i < 10; i++) begin
         rs485_pl_di <= bits[i];
         repeat (CLKS_PER_BIT) @(posedge clk);
      end
   endtask

   task automatic do_frame(input logic [1:0] op, input int m, input logic [15:0] arg,
                           input bit ignored, output int steps);
      logic        d;
      logic [23:0] reply;
      ref_model(op, m, arg, ignored, steps, d, reply);
      if (steps != 0) begin
         mon.expect_move(m, steps, d);
      end
      if (op == OP_SET_PERIOD && m < NMOTORS) begin
         mon.expect_half(m, int'(model_half[m]));
      end
      if (op == OP_STATUS && m < NMOTORS) begin
         mon.expect_byte(reply[23:16]);
         mon.expect_byte(reply[15:8]);
         mon.expect_byte(reply[7:0]);
      end
      send_byte({op, MOTOR_IDX_W'(m)});
      send_byte(arg[15:8]);
      send_byte(arg[7:0]);
   endtask

   //------------------------------------------------
   // bounded waits
   //------------------------------------------------
   task automatic abort_on_timeout(input string what);
      $display("timeout while waiting for %s", what);
      mon.note_timeout();
      mon.report(mcoi_xu5_design_complete_inst.chk_inst.fail_cnt);
      $display("Regression failed");
      $finish;
   endtask

   task automatic wait_reset();
      int n;
      n = 0;
      @(negedge clk);
      while (rst) begin
         if (n == WAIT_LIMIT) begin
            abort_on_timeout("reset release");
         end
         n++;
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   task automatic wait_busy(input int m, input logic level);
      int n;
      n = 0;
      @(negedge clk);
      while (busy[m] !== level) begin
         if (n == WAIT_LIMIT) begin
            abort_on_timeout($sformatf("busy of motor %0d to reach %0d", m, level));
         end
         n++;
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   task automatic wait_all_idle();
      int n;
      n = 0;
      @(negedge clk);
      while (busy !== '0) begin
         if (n == WAIT_LIMIT) begin
            abort_on_timeout("all motors to stop");
         end
         n++;
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   task automatic wait_replies();
      int n;
      n = 0;
      @(negedge clk);
      while (mon.pending_bytes() != 0) begin
         if (n == WAIT_LIMIT) begin
            abort_on_timeout("status reply bytes");
         end
         n++;
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   // a move that runs waits for its start, then for the end
   task automatic run_move(input logic [1:0] op, input int m, input logic [15:0] n);
      int steps;
      do_frame(op, m, n, 1'b0, steps);
      if (steps != 0) begin
         wait_busy(m, 1'b1);
      end
      wait_all_idle();
   endtask

   task automatic query_status(input int m);
      int steps;
      do_frame(OP_STATUS, m, 16'($urandom), 1'b0, steps);
      wait_replies();
   endtask

   //------------------------------------------------
   // test sequence
   //------------------------------------------------
   initial begin
      int          steps;
      int          m;
      int          errs;
      logic [1:0]  op;
      rs485_pl_di <= 1'b1;
      void'($urandom(32'h8032_ca96));
      for (int i = 0; i < NMOTORS; i++) begin
         model_pos[i]  = '0;
         model_half[i] = DEFAULT_HALF_PERIOD;
         model_dir[i]  = 1'b0;
      end
      wait_reset();

      mon.set_test("reset state");
      mon.check_idle();
      // back on a rising edge before the first frame
      @(posedge clk);
      for (int i = 0; i < NMOTORS; i++) begin
         query_status(i);
      end

      // short periods keep the runs brief
      mon.set_test("period change");
      for (int i = 0; i < NMOTORS; i++) begin
         do_frame(OP_SET_PERIOD, i, 16'($urandom_range(6, 1)), 1'b0, steps);
         run_move(OP_MOVE_FWD, i, 16'($urandom_range(6, 2)));
      end

      mon.set_test("random moves");
      repeat (12) begin
         m  = int'($urandom_range(NMOTORS - 1));
         op = $urandom_range(1) != 0 ? OP_MOVE_REV : OP_MOVE_FWD;
         run_move(op, m, 16'($urandom_range(20, 1)));
         query_status(m);
      end

      // 40 steps of 8 clocks outlast the second frame
      mon.set_test("busy rule");
      m = int'($urandom_range(NMOTORS - 1));
      do_frame(OP_SET_PERIOD, m, 16'd4, 1'b0, steps);
      do_frame(OP_MOVE_FWD, m, 16'd40, 1'b0, steps);
      do_frame(OP_MOVE_REV, m, 16'd7, 1'b1, steps);
      wait_all_idle();
      query_status(m);

      mon.set_test("bad frames");
      repeat (6) begin
         m  = int'($urandom_range(63, NMOTORS));
         op = 2'($urandom_range(3));
         do_frame(op, m, 16'($urandom_range(20, 1)), 1'b0, steps);
      end
      // zero length move on a real motor
      do_frame(OP_MOVE_REV, 0, 16'd0, 1'b0, steps);
      // window for any stray step or reply
      repeat (40 * CLKS_PER_BIT) @(posedge clk);
      wait_all_idle();

      mon.set_test("back to back status");
      for (int i = 0; i < NMOTORS; i++) begin
         do_frame(OP_STATUS, i, 16'($urandom), 1'b0, steps);
      end
      wait_replies();

      mon.final_check();
      errs = mcoi_xu5_design_complete_inst.chk_inst.fail_cnt;
      mon.report(errs);
      if (mon.value_errs == 0 && errs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule : mcoi_tb

//--- verif/tb_clk.sv
//------------------------------------------------
// testbench clock and reset source
// 10 ns clock, rst held high for RST_CYCLES edges
//------------------------------------------------

`timescale 1ns/1ns

module tb_clk #(
   parameter int RST_CYCLES = 8
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // synchronous reset, released on a rising edge
   initial begin
      rst <= 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule : tb_clk
